// ==== lane_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Lane widths, opcodes, instruction word forms and pipeline payload types
////////////////////////////////////////////////////////////////////////////

package lane_pkg;

	localparam int data_width  = 32;
	localparam int num_regs    = 16;
	localparam int ibuff_depth = 4;
	localparam int ibuff_ptr_w = $clog2(ibuff_depth);

	typedef logic [$clog2(num_regs)-1:0] reg_idx_t;
	typedef logic [data_width-1:0]       data_t;
	typedef logic [5:0]                  issue_no_t;

	typedef enum logic [3:0] {
		op_add      = 4'h0,
		op_sub      = 4'h1,
		op_and      = 4'h2,
		op_or       = 4'h3,
		op_xor      = 4'h4,
		op_addi     = 4'h5,
		op_shli     = 4'h6,
		op_lane_off = 4'h7,
		op_lane_on  = 4'h8
	} op_t;

	// Register-register form
	typedef struct packed {
		op_t        op;
		reg_idx_t   dst;
		reg_idx_t   src1;
		reg_idx_t   src2;
		logic [15:0] pad;
	} alu_form_t;

	// Immediate form, imm sits in the low half
	typedef struct packed {
		op_t        op;
		reg_idx_t   dst;
		reg_idx_t   src1;
		logic [3:0]  pad;
		logic [15:0] imm;
	} imm_form_t;

	typedef union packed {
		alu_form_t alu;
		imm_form_t imm;
	} instr_u;

	typedef struct packed {
		instr_u    instr;
		issue_no_t issue_no;
	} cmd_t;

	typedef struct packed {
		issue_no_t issue_no;
		reg_idx_t  dst;
		data_t     data;
		logic      lane_on;   // Write allowed for this result
	} result_t;

	typedef struct packed {
		issue_no_t issue_no;
		reg_idx_t  dst;
		data_t     data;
		logic      written;
	} commit_t;

endpackage

// ==== cmd_intake.sv ====
////////////////////////////////////////////////////////////////////////////
// Command intake with four-phase req/ack and a command ring buffer
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cmd_intake (
	input  logic           clock,
	input  logic           reset,
	input  logic           cmd_req,
	input  lane_pkg::cmd_t cmd,
	output logic           cmd_ack,
	input  logic           buf_pop,
	output logic           buf_valid,
	output lane_pkg::cmd_t buf_cmd
);
	import lane_pkg::*;

	cmd_t                   ring [ibuff_depth];
	logic [ibuff_ptr_w-1:0] wr_ptr;
	logic [ibuff_ptr_w-1:0] rd_ptr;
	logic [ibuff_ptr_w:0]   count;
	logic                   full;
	logic                   push;
	logic                   pop;

	assign full = (count == ibuff_depth);
	assign push = cmd_req & ~cmd_ack & ~full;   // Held off while full
	assign pop  = buf_pop & buf_valid;

	assign buf_valid = (count != '0);
	assign buf_cmd   = ring[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_ack <= 1'b0;
		end else if (push) begin
			cmd_ack <= 1'b1;
		end else if (!cmd_req) begin
			cmd_ack <= 1'b0;   // Req seen low
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Ring buffer
	always_ff @(posedge clock) begin
		if (push) begin
			ring[wr_ptr] <= cmd;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== lane_regfile.sv ====
////////////////////////////////////////////////////////////////////////////
// Lane register file with two registered read ports and one write port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_regfile (
	input  logic               clock,
	input  logic               reset,
	input  lane_pkg::reg_idx_t rd_idx1,
	input  lane_pkg::reg_idx_t rd_idx2,
	output lane_pkg::data_t    rd_data1,
	output lane_pkg::data_t    rd_data2,
	input  logic               wr_en,
	input  lane_pkg::reg_idx_t wr_idx,
	input  lane_pkg::data_t    wr_data
);
	import lane_pkg::*;

	data_t regs [num_regs];

	always_ff @(posedge clock) begin
		if (reset) begin
			regs <= '{default: '0};
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// Read data valid the cycle after the index
	always_ff @(posedge clock) begin
		if (reset) begin
			rd_data1 <= '0;
			rd_data2 <= '0;
		end else begin
			rd_data1 <= regs[rd_idx1];
			rd_data2 <= regs[rd_idx2];
		end
	end

endmodule

// ==== lane_ctrl_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Lane enable register driven by lane-control instructions
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_ctrl_regs (
	input  logic clock,
	input  logic reset,
	input  logic lane_off_req,
	input  logic lane_on_req,
	output logic lane_on
);

	logic en_next;

	// Off wins if both ever arrive together
	always_comb begin
		en_next = lane_on;
		if (lane_on_req)
			en_next = 1'b1;
		if (lane_off_req)
			en_next = 1'b0;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			lane_on <= 1'b1;   // Lane comes up enabled
		end else begin
			lane_on <= en_next;
		end
	end

endmodule

// ==== lane_exec.sv ====
////////////////////////////////////////////////////////////////////////////
// Issue sequencer, operand read and execution of one command at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_exec (
	input  logic               clock,
	input  logic               reset,
	input  logic               buf_valid,
	input  lane_pkg::cmd_t     buf_cmd,
	output logic               buf_pop,
	output lane_pkg::reg_idx_t rd_idx1,
	output lane_pkg::reg_idx_t rd_idx2,
	input  lane_pkg::data_t    rd_data1,
	input  lane_pkg::data_t    rd_data2,
	input  logic               lane_on,
	output logic               lane_off_req,
	output logic               lane_on_req,
	input  logic               slot_busy,
	output logic               res_valid,
	output lane_pkg::result_t  res
);
	import lane_pkg::*;

	typedef enum logic [1:0] {st_idle, st_read, st_exec} state_t;

	state_t state;
	cmd_t   cur;
	op_t    op;
	data_t  imm_sext;
	data_t  alu_out;
	logic   is_ctrl;

	// Next issue waits for the commit slot to drain
	assign buf_pop = (state == st_idle) & buf_valid & ~slot_busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: if (buf_pop) state <= st_read;
				st_read: state <= st_exec;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (buf_pop)
			cur <= buf_cmd;
	end

	////////////////////////////////////////////////////////////////////////////
	// Decode both forms of the instruction word
	assign op       = cur.instr.alu.op;
	assign rd_idx1  = cur.instr.alu.src1;
	assign rd_idx2  = cur.instr.alu.src2;
	assign imm_sext = {{(data_width-16){cur.instr.imm.imm[15]}}, cur.instr.imm.imm};
	assign is_ctrl  = (op == op_lane_off) | (op == op_lane_on);

	always_comb begin
		case (op)
			op_add:  alu_out = rd_data1 + rd_data2;
			op_sub:  alu_out = rd_data1 - rd_data2;
			op_and:  alu_out = rd_data1 & rd_data2;
			op_or:   alu_out = rd_data1 | rd_data2;
			op_xor:  alu_out = rd_data1 ^ rd_data2;
			op_addi: alu_out = rd_data1 + imm_sext;
			op_shli: alu_out = rd_data1 << cur.instr.imm.imm[4:0];
			default: alu_out = '0;   // Lane control
		endcase
	end

	assign res_valid    = (state == st_exec);
	assign lane_off_req = res_valid & (op == op_lane_off);
	assign lane_on_req  = res_valid & (op == op_lane_on);
	assign res = '{issue_no: cur.issue_no, dst: cur.instr.alu.dst, data: alu_out,
		lane_on: lane_on & ~is_ctrl};

endmodule

// ==== lane_commit.sv ====
////////////////////////////////////////////////////////////////////////////
// Single-entry commit slot, commit req/grant and register write-back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_commit (
	input  logic               clock,
	input  logic               reset,
	input  logic               res_valid,
	input  lane_pkg::result_t  res,
	output logic               slot_busy,
	output logic               commit_req,
	output lane_pkg::commit_t  commit,
	input  logic               commit_grant,
	output logic               wr_en,
	output lane_pkg::reg_idx_t wr_idx,
	output lane_pkg::data_t    wr_data
);
	import lane_pkg::*;

	typedef enum logic [1:0] {c_idle, c_req, c_release} state_t;

	state_t  state;
	result_t slot;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= c_idle;
		end else begin
			case (state)
				c_idle:    if (res_valid) state <= c_req;
				c_req:     if (commit_grant) state <= c_release;
				c_release: if (!commit_grant) state <= c_idle;   // Grant low frees slot
				default:   state <= c_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (res_valid && state == c_idle)
			slot <= res;
	end

	assign slot_busy  = (state != c_idle);
	assign commit_req = (state == c_req);

	assign commit = '{issue_no: slot.issue_no, dst: slot.dst, data: slot.data,
		written: slot.lane_on};

	////////////////////////////////////////////////////////////////////////////
	// Write-back on the grant edge
	assign wr_en   = commit_req & commit_grant & slot.lane_on;
	assign wr_idx  = slot.dst;
	assign wr_data = slot.data;

endmodule

// ==== lane_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// SIMD lane top level
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lane_unit (
	input  logic              clock,
	input  logic              reset,
	input  logic              cmd_req,
	input  lane_pkg::cmd_t    cmd,
	output logic              cmd_ack,
	output logic              commit_req,
	output lane_pkg::commit_t commit,
	input  logic              commit_grant,
	output logic              lane_status
);
	import lane_pkg::*;

	logic     buf_valid;
	cmd_t     buf_cmd;
	logic     buf_pop;
	reg_idx_t rd_idx1;
	reg_idx_t rd_idx2;
	data_t    rd_data1;
	data_t    rd_data2;
	logic     lane_on;
	logic     lane_off_req;
	logic     lane_on_req;
	logic     slot_busy;
	logic     res_valid;
	result_t  res;
	logic     wr_en;
	reg_idx_t wr_idx;
	data_t    wr_data;

	assign lane_status = lane_on;

	cmd_intake intake0 (
		.clock, .reset, .cmd_req, .cmd, .cmd_ack,
		.buf_pop, .buf_valid, .buf_cmd
	);

	lane_regfile regfile0 (
		.clock, .reset, .rd_idx1, .rd_idx2, .rd_data1, .rd_data2,
		.wr_en, .wr_idx, .wr_data
	);

	lane_ctrl_regs ctrl0 (
		.clock, .reset, .lane_off_req, .lane_on_req, .lane_on
	);

	lane_exec exec0 (
		.clock, .reset, .buf_valid, .buf_cmd, .buf_pop,
		.rd_idx1, .rd_idx2, .rd_data1, .rd_data2,
		.lane_on, .lane_off_req, .lane_on_req,
		.slot_busy, .res_valid, .res
	);

	lane_commit commit0 (
		.clock, .reset, .res_valid, .res, .slot_busy,
		.commit_req, .commit, .commit_grant,
		.wr_en, .wr_idx, .wr_data
	);

endmodule

// ==== tb_lane_tasks.svh ====
////////////////////////////////////////////////////////////////////////////
// Directed lane tests, intake and commit handshakes, register file model
////////////////////////////////////////////////////////////////////////////

	int        seed;
	issue_no_t next_issue;
	data_t     model_regs [num_regs];
	logic      model_lane_on;

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic logic [15:0] rand_imm();
		int r;
		r = $random(seed);
		return r[15:0];
	endfunction

	function automatic cmd_t make_alu(input op_t op, input int dst, input int s1, input int s2);
		cmd_t c;
		c = '0;
		c.instr.alu.op   = op;
		c.instr.alu.dst  = reg_idx_t'(dst);
		c.instr.alu.src1 = reg_idx_t'(s1);
		c.instr.alu.src2 = reg_idx_t'(s2);
		c.issue_no       = next_issue;
		next_issue       = next_issue + 1'b1;
		return c;
	endfunction

	function automatic cmd_t make_imm(input op_t op, input int dst, input int s1,
		input logic [15:0] imm);
		cmd_t c;
		c = '0;
		c.instr.imm.op   = op;
		c.instr.imm.dst  = reg_idx_t'(dst);
		c.instr.imm.src1 = reg_idx_t'(s1);
		c.instr.imm.imm  = imm;
		c.issue_no       = next_issue;
		next_issue       = next_issue + 1'b1;
		return c;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	function automatic data_t model_data(input cmd_t c);
		data_t       a;
		data_t       b;
		logic [15:0] imm;
		a   = model_regs[c.instr.alu.src1];
		b   = model_regs[c.instr.alu.src2];
		imm = c.instr.imm.imm;
		case (c.instr.alu.op)
			op_add:  return a + b;
			op_sub:  return a - b;
			op_and:  return a & b;
			op_or:   return a | b;
			op_xor:  return a ^ b;
			op_addi: return a + {{16{imm[15]}}, imm};
			op_shli: return a << (imm % 32);
			default: return '0;
		endcase
	endfunction

	task automatic expect_commit(input string test, input cmd_t c, input commit_t got);
		logic  ctrl;
		data_t exp_data;
		logic  exp_written;
		ctrl        = (c.instr.alu.op == op_lane_off) || (c.instr.alu.op == op_lane_on);
		exp_data    = ctrl ? '0 : model_data(c);
		exp_written = model_lane_on && !ctrl;
		check_val(test, "issue_no", c.issue_no, got.issue_no);
		check_val(test, "dst", c.instr.alu.dst, got.dst);
		check_val(test, "data", exp_data, got.data);
		check_val(test, "written", exp_written, got.written);
		if (exp_written)
			model_regs[c.instr.alu.dst] = exp_data;
		if (ctrl)
			model_lane_on = (c.instr.alu.op == op_lane_on);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Handshakes
	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		@(negedge clock);
		while (cmd_ack !== level) begin
			n++;
			if (n > wait_limit)
				fail_stop(level ? "timeout: cmd_ack never rose" : "timeout: cmd_ack never fell");
			@(negedge clock);
		end
	endtask

	task automatic send_cmd(input cmd_t c);
		@(posedge clock);
		cmd_req <= 1'b1;
		cmd     <= c;
		wait_ack(1'b1);
		@(posedge clock);
		cmd_req <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic take_commit(input int delay, output commit_t got);
		int n;
		n = 0;
		@(negedge clock);
		while (commit_req !== 1'b1) begin
			n++;
			if (n > wait_limit)
				fail_stop("timeout: commit_req never rose");
			@(negedge clock);
		end
		got = commit;
		repeat (delay) @(posedge clock);
		@(posedge clock);
		commit_grant <= 1'b1;
		n = 0;
		@(negedge clock);
		while (commit_req !== 1'b0) begin
			n++;
			if (n > wait_limit)
				fail_stop("timeout: commit_req stayed high after the grant");
			@(negedge clock);
		end
		@(posedge clock);
		commit_grant <= 1'b0;
	endtask

	task automatic expect_no_ack(input string test, input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (cmd_ack !== 1'b0)
				fail_stop($sformatf("%s: cmd_ack rose while the command buffer was full", test));
		end
	endtask

	task automatic expect_no_commit(input string test, input int cycles);
		repeat (cycles) begin
			@(negedge clock);
			if (commit_req !== 1'b0)
				fail_stop($sformatf("%s: commit_req rose with no command left", test));
		end
	endtask

	task automatic run_one(input string test, input cmd_t c, input int delay,
		output commit_t got);
		send_cmd(c);
		take_commit(delay, got);
		expect_commit(test, c, got);
	endtask

	task automatic check_status(input string test, input logic exp);
		@(negedge clock);
		check_val(test, "lane_status", exp, lane_status);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	task automatic test_reset_state();
		commit_t got;
		int      i;
		for (i = 0; i < num_regs; i++)
			model_regs[i] = '0;
		model_lane_on = 1'b1;
		check_status("reset_state", 1'b1);
		check_val("reset_state", "commit_req", 1'b0, commit_req);
		run_one("reset_state", make_alu(op_add, 3, 1, 2), 0, got);
		check_val("reset_state", "data", '0, got.data);
		check_val("reset_state", "written", 1'b1, got.written);
	endtask

	task automatic test_alu_ops();
		commit_t got;
		run_one("alu_ops addi", make_imm(op_addi, 1, 0, rand_imm()), 0, got);
		run_one("alu_ops addi", make_imm(op_addi, 2, 0, rand_imm()), 1, got);
		run_one("alu_ops addi", make_imm(op_addi, 3, 1, rand_imm()), 0, got);
		run_one("alu_ops add", make_alu(op_add, 4, 1, 2), 2, got);
		run_one("alu_ops sub", make_alu(op_sub, 5, 1, 2), 0, got);
		run_one("alu_ops and", make_alu(op_and, 6, 1, 3), 0, got);
		run_one("alu_ops or", make_alu(op_or, 7, 2, 3), 1, got);
		run_one("alu_ops xor", make_alu(op_xor, 8, 1, 3), 0, got);
		run_one("alu_ops shli", make_imm(op_shli, 9, 3, rand_imm()), 0, got);
		// Read back the results
		run_one("alu_ops readback", make_alu(op_add, 10, 4, 5), 0, got);
		run_one("alu_ops readback", make_alu(op_add, 11, 6, 7), 0, got);
		run_one("alu_ops readback", make_alu(op_add, 12, 8, 9), 0, got);
	endtask

	task automatic test_issue_order();
		cmd_t    burst [6];
		commit_t got;
		int      i;
		int      j;
		// First five opcodes are the register ops
		for (i = 0; i < 6; i++)
			burst[i] = make_alu(op_t'(rand_below(5)), 1 + rand_below(15),
				rand_below(16), rand_below(16));
		fork
			for (i = 0; i < 6; i++)
				send_cmd(burst[i]);
			for (j = 0; j < 6; j++) begin
				take_commit(j % 3, got);
				expect_commit("issue_order", burst[j], got);
			end
		join
		expect_no_commit("issue_order", 8);
	endtask

	task automatic test_lane_off();
		commit_t got;
		run_one("lane_off", make_alu(op_lane_off, 0, 0, 0), 0, got);
		check_status("lane_off", 1'b0);
		run_one("lane_off addi", make_imm(op_addi, 4, 4, 16'h0077), 0, got);
		check_val("lane_off addi", "written", 1'b0, got.written);
		run_one("lane_off add", make_alu(op_add, 5, 1, 2), 1, got);
		check_val("lane_off add", "written", 1'b0, got.written);
		run_one("lane_on", make_alu(op_lane_on, 0, 0, 0), 0, got);
		check_status("lane_on", 1'b1);
		run_one("lane_on readback", make_alu(op_add, 13, 4, 0), 0, got);   // r4, r5 unchanged
		run_one("lane_on readback", make_alu(op_add, 14, 5, 0), 0, got);
	endtask

	task automatic test_back_pressure();
		cmd_t    bp [6];
		commit_t got;
		int      i;
		int      j;
		for (i = 0; i < 6; i++)
			bp[i] = make_imm(op_addi, 1 + i, i, rand_imm());
		// Slot plus buffer hold five while grant is withheld
		for (i = 0; i < 5; i++)
			send_cmd(bp[i]);
		@(posedge clock);
		cmd_req <= 1'b1;
		cmd     <= bp[5];
		expect_no_ack("back_pressure", 16);
		fork
			begin
				wait_ack(1'b1);
				@(posedge clock);
				cmd_req <= 1'b0;
				wait_ack(1'b0);
			end
			for (j = 0; j < 6; j++) begin
				take_commit(1, got);
				expect_commit("back_pressure", bp[j], got);
			end
		join
		expect_no_commit("back_pressure", 8);
	endtask

// ==== tb_lane_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top for the SIMD lane with clock, reset, DUT and test sequence
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lane_unit;
	import lane_pkg::*;

	localparam int wait_limit = 200;   // Cycles before any wait gives up

	logic    clock;
	logic    reset;
	logic    cmd_req;
	cmd_t    cmd;
	logic    cmd_ack;
	logic    commit_req;
	commit_t commit;
	logic    commit_grant;
	logic    lane_status;
	int      error_count;

	lane_unit dut0 (
		.clock, .reset, .cmd_req, .cmd, .cmd_ack,
		.commit_req, .commit, .commit_grant, .lane_status
	);

	`include "tb_lane_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////////////////////////////////////////
	// Failure handling and value checker
	task automatic fail_stop(input string what);
		error_count = error_count + 1;
		$display("%s", what);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_val(input string test, input string field,
		input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			fail_stop($sformatf("error: %s %s expected %h actual %h", test, field, exp, act));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		error_count  = 0;
		seed         = 52504;
		next_issue   = '0;
		reset        = 1'b1;
		cmd_req      = 1'b0;
		cmd          = '0;
		commit_grant = 1'b0;
		repeat (2) @(posedge clock);
		reset <= 1'b0;

		test_reset_state();
		test_alu_ops();
		test_issue_order();
		test_lane_off();
		test_back_pressure();

		repeat (4) @(posedge clock);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+.
lane_pkg.sv
cmd_intake.sv
lane_regfile.sv
lane_ctrl_regs.sv
lane_exec.sv
lane_commit.sv
lane_unit.sv
tb_lane_unit.sv

// ==== Bender.yml ====
package:
  name: lane_unit

sources:
  - files:
      - lane_pkg.sv
      - cmd_intake.sv
      - lane_regfile.sv
      - lane_ctrl_regs.sv
      - lane_exec.sv
      - lane_commit.sv
      - lane_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lane_unit.sv
